/* design/memtest_pkg.sv */
// ============================
// Memory read test engine shared definitions
// Widths, enums and bus structs
// ============================
`default_nettype none

package memtest_pkg;

    // Bus and field widths
    localparam int LINE_ADDR_WIDTH  = 29;
    localparam int BYTE_IDX_WIDTH   = 3;
    localparam int DATA_WIDTH       = 64;
    localparam int ID_WIDTH         = 4;
    localparam int BURST_LEN_WIDTH  = 8;
    localparam int OFFSET_WIDTH     = 16;
    localparam int NUM_BURSTS_WIDTH = 16;
    localparam int CSR_DATA_WIDTH   = 64;
    localparam int NUM_EVENTS       = 3;

    // CSR index, write side
    typedef enum logic [3:0] {
        CSR_RD_BASE    = 4'd0,
        CSR_BURSTS_REQ = 4'd1,
        CSR_RD_CTRL    = 4'd2,
        CSR_ADDR_MASK  = 4'd4,
        CSR_CHECKSUM   = 4'd5,
        CSR_READY_MASK = 4'd6
    } csr_idx_e;

    // Read indices that share an encoding with a write index
    localparam csr_idx_e CSR_CONFIG      = CSR_RD_BASE;
    localparam csr_idx_e CSR_LINES_RESP  = CSR_RD_CTRL;
    localparam csr_idx_e CSR_BURSTS_RESP = CSR_READY_MASK;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_DONE
    } rd_state_e;

    // Bit position of each counted event
    typedef enum logic [1:0] {
        EV_BURST_REQ  = 2'd0,
        EV_LINE_RESP  = 2'd1,
        EV_BURST_RESP = 2'd2
    } event_e;

    // Run configuration
    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0]  base_addr;
        logic [OFFSET_WIDTH-1:0]     start_offset;
        logic [OFFSET_WIDTH-1:0]     addr_mask;
        logic [NUM_BURSTS_WIDTH-1:0] num_bursts;
        logic [BURST_LEN_WIDTH-1:0]  burst_len;
    } rd_cfg_t;

    // AR channel payload, len is beats minus one
    typedef struct packed {
        logic [31:0]                addr;
        logic [BURST_LEN_WIDTH-1:0] len;
        logic [ID_WIDTH-1:0]        id;
    } ar_req_t;

    // R channel payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } r_beat_t;

endpackage

`default_nettype wire

/* design/memtest_csr_regs.sv */
// ============================
// CSR write decode
// Holds the read run configuration and R ready mask
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_csr_regs
(
    input  wire logic                                clk,
    input  wire logic                                state_reset,

    // CSR write port
    input  wire logic                                csr_wr,
    input  wire memtest_pkg::csr_idx_e               csr_wr_idx,
    input  wire logic [memtest_pkg::CSR_DATA_WIDTH-1:0] csr_wr_data,

    // Configuration out
    output memtest_pkg::rd_cfg_t                     rd_cfg,
    output logic [31:0]                              ready_mask
);

    import memtest_pkg::*;

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            // Masks open, everything else cleared
            rd_cfg.base_addr    <= '0;
            rd_cfg.start_offset <= '0;
            rd_cfg.addr_mask    <= '1;
            rd_cfg.num_bursts   <= '0;
            rd_cfg.burst_len    <= '0;
            ready_mask          <= '1;
        end
        else if (csr_wr)
        begin
            case (csr_wr_idx)
                // Line address of the read buffer
                CSR_RD_BASE:
                    rd_cfg.base_addr <= csr_wr_data[LINE_ADDR_WIDTH-1:0];
                // Burst count, start offset and burst length
                CSR_RD_CTRL:
                begin
                    rd_cfg.num_bursts   <= csr_wr_data[47:32];
                    rd_cfg.start_offset <= csr_wr_data[31:16];
                    rd_cfg.burst_len    <= csr_wr_data[BURST_LEN_WIDTH-1:0];
                end
                // Limits the range the running offset can reach
                CSR_ADDR_MASK:
                    rd_cfg.addr_mask <= csr_wr_data[OFFSET_WIDTH-1:0];
                // Low bit is the first cycle's rready
                CSR_READY_MASK:
                    ready_mask <= csr_wr_data[31:0];
                default:
                begin
                    // Other indices are read only
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/memtest_rd_requester.sv */
// ============================
// Read burst requester
// Issues AR bursts over a masked offset range
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_rd_requester
(
    input  wire logic                 clk,
    input  wire logic                 state_reset,
    input  wire logic                 start,
    input  wire logic                 state_run,
    input  wire memtest_pkg::rd_cfg_t rd_cfg,

    // AR channel
    output logic                      arvalid,
    output memtest_pkg::ar_req_t      ar,
    input  wire logic                 arready,

    output memtest_pkg::rd_state_e    rd_state
);

    import memtest_pkg::*;

    logic [OFFSET_WIDTH-1:0]     cur_offset;
    logic [ID_WIDTH-1:0]         cur_id;
    logic [NUM_BURSTS_WIDTH-1:0] bursts_left;
    logic                        unlimited;
    logic                        ar_held;
    logic                        ar_accept;
    logic [LINE_ADDR_WIDTH-1:0]  line_addr;

    // A request already on the bus stays up even if run drops
    assign arvalid   = (rd_state == RD_ISSUE) && (state_run || ar_held);
    assign ar_accept = arvalid && arready;

    // OR in the masked offset, base is assumed aligned to the mask
    assign line_addr = rd_cfg.base_addr | LINE_ADDR_WIDTH'(cur_offset & rd_cfg.addr_mask);

    always_comb
    begin
        ar.addr = {line_addr, BYTE_IDX_WIDTH'(0)};
        ar.len  = rd_cfg.burst_len - BURST_LEN_WIDTH'(1);
        ar.id   = cur_id;
    end

    // ============================
    // Request FSM
    // ============================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_state    <= RD_IDLE;
            ar_held     <= 1'b0;
            cur_offset  <= '0;
            cur_id      <= '0;
            bursts_left <= '0;
            unlimited   <= 1'b0;
        end
        else if (start)
        begin
            // No buffer configured means nothing to read
            rd_state    <= (rd_cfg.base_addr == '0) ? RD_DONE : RD_ISSUE;
            ar_held     <= 1'b0;
            cur_offset  <= rd_cfg.start_offset;
            cur_id      <= '0;
            bursts_left <= rd_cfg.num_bursts;
            unlimited   <= (rd_cfg.num_bursts == '0);
        end
        else
        begin
            ar_held <= arvalid && !arready;

            if (ar_accept)
            begin
                cur_offset  <= cur_offset + OFFSET_WIDTH'(rd_cfg.burst_len);
                cur_id      <= cur_id + 1'b1;
                bursts_left <= bursts_left - 1'b1;
                // Last counted burst ends the run
                if (!unlimited && (bursts_left == NUM_BURSTS_WIDTH'(1)))
                begin
                    rd_state <= RD_DONE;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/memtest_rd_monitor.sv */
// ============================
// Read channel monitor
// R ready pacing, checksum and event strobes
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_rd_monitor
(
    input  wire logic                               clk,
    input  wire logic                               state_reset,
    input  wire logic                               start,
    input  wire logic [31:0]                        ready_mask,

    // AR handshake, observed only
    input  wire logic                               arvalid,
    input  wire logic                               arready,

    // R channel
    input  wire logic                               rvalid,
    input  wire memtest_pkg::r_beat_t               r,
    output logic                                    rready,

    output logic [31:0]                             checksum,
    output logic [memtest_pkg::NUM_EVENTS-1:0]      events
);

    import memtest_pkg::*;

    logic [31:0] r_ready_mask;
    logic [31:0] beat_word;

    // Bit 0 paces the current cycle
    assign rready = r_ready_mask[0];

    // Rotate right so bit k lands on cycle k after start
    always_ff @(posedge clk)
    begin
        if (state_reset)
            r_ready_mask <= '1;
        else if (start)
            r_ready_mask <= ready_mask;
        else
            r_ready_mask <= {r_ready_mask[0], r_ready_mask[31:1]};
    end

    // ============================
    // Registered strobes and sum
    // ============================
    always_ff @(posedge clk)
    begin
        // Low word of each beat, summed a cycle later
        beat_word <= r.data[31:0];

        if (state_reset || start)
        begin
            events   <= '0;
            checksum <= '0;
        end
        else
        begin
            events[EV_BURST_REQ]  <= arvalid && arready;
            events[EV_LINE_RESP]  <= rvalid && rready;
            events[EV_BURST_RESP] <= rvalid && rready && r.last;

            if (events[EV_LINE_RESP])
                checksum <= checksum + beat_word;
        end
    end

endmodule

`default_nettype wire

/* design/memtest_event_counter.sv */
// ============================
// Event counter, cleared per run
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_event_counter
#(
    parameter int COUNTER_WIDTH = 48
)
(
    input  wire logic                     clk,
    input  wire logic                     state_reset,
    input  wire logic                     start,
    input  wire logic                     incr,
    output logic [COUNTER_WIDTH-1:0]      value
);

    always_ff @(posedge clk)
    begin
        // New run starts from zero
        if (state_reset || start)
            value <= '0;
        else if (incr)
            value <= value + COUNTER_WIDTH'(1);
    end

endmodule

`default_nettype wire

/* design/memtest_status_readback.sv */
// ============================
// CSR read mux and activity flag
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_status_readback
#(
    parameter int         COUNTER_WIDTH = 48,
    parameter logic [4:0] ENGINE_NUMBER = 5'd0
)
(
    input  wire logic                                  clk,
    input  wire logic                                  state_reset,
    input  wire logic                                  state_run,
    input  wire memtest_pkg::rd_state_e                rd_state,
    input  wire logic [memtest_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counts,
    input  wire logic [31:0]                           checksum,
    input  wire memtest_pkg::csr_idx_e                 csr_rd_idx,
    output logic [memtest_pkg::CSR_DATA_WIDTH-1:0]     csr_rd_data,
    output logic                                       active
);

    import memtest_pkg::*;

    logic [CSR_DATA_WIDTH-1:0] config_word;
    logic                      busy;
    logic                      busy_q;

    // Requester still has work while running
    assign busy = state_run && (rd_state != RD_DONE);

    always_comb
    begin
        config_word        = '0;
        config_word[46:42] = ENGINE_NUMBER;
        config_word[34]    = active;
        config_word[33]    = state_run;
        // Largest burst the length field can hold
        config_word[14:0]  = 15'((1 << BURST_LEN_WIDTH) - 1);
    end

    always_comb
    begin
        case (csr_rd_idx)
            CSR_CONFIG:      csr_rd_data = config_word;
            CSR_BURSTS_REQ:  csr_rd_data = CSR_DATA_WIDTH'(counts[EV_BURST_REQ]);
            CSR_LINES_RESP:  csr_rd_data = CSR_DATA_WIDTH'(counts[EV_LINE_RESP]);
            CSR_CHECKSUM:    csr_rd_data = CSR_DATA_WIDTH'(checksum);
            CSR_BURSTS_RESP: csr_rd_data = CSR_DATA_WIDTH'(counts[EV_BURST_RESP]);
            default:         csr_rd_data = '0;
        endcase
    end

    // busy_q covers the two cycle lag before the last request is counted
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            busy_q <= 1'b0;
            active <= 1'b0;
        end
        else
        begin
            busy_q <= busy;
            active <= busy || busy_q ||
                      (counts[EV_BURST_REQ] != counts[EV_BURST_RESP]);
        end
    end

endmodule

`default_nettype wire

/* design/memtest_engine_top.sv */
// ============================
// Memory read test engine top
// CSR block, AR requester, R monitor and counters
// ============================
`timescale 1ns/1ns
`default_nettype none

module memtest_engine_top
#(
    parameter int         COUNTER_WIDTH = 48,
    parameter logic [4:0] ENGINE_NUMBER = 5'd0
)
(
    input  wire logic                                   clk,
    input  wire logic                                   state_reset,

    // CSR write
    input  wire logic                                   csr_wr,
    input  wire memtest_pkg::csr_idx_e                  csr_wr_idx,
    input  wire logic [memtest_pkg::CSR_DATA_WIDTH-1:0] csr_wr_data,

    // CSR read
    input  wire memtest_pkg::csr_idx_e                  csr_rd_idx,
    output logic [memtest_pkg::CSR_DATA_WIDTH-1:0]      csr_rd_data,

    // Run control
    input  wire logic                                   start,
    input  wire logic                                   state_run,
    output logic                                        active,

    // AR channel
    output logic                                        arvalid,
    output memtest_pkg::ar_req_t                        ar,
    input  wire logic                                   arready,

    // R channel
    input  wire logic                                   rvalid,
    input  wire memtest_pkg::r_beat_t                   r,
    output logic                                        rready
);

    import memtest_pkg::*;

    rd_cfg_t                                   rd_cfg;
    logic [31:0]                               ready_mask;
    rd_state_e                                 rd_state;
    logic [31:0]                               checksum;
    logic [NUM_EVENTS-1:0]                     events;
    logic [NUM_EVENTS-1:0][COUNTER_WIDTH-1:0]  counts;

    memtest_csr_regs u_csr_regs (
        .clk, .state_reset, .csr_wr, .csr_wr_idx, .csr_wr_data,
        .rd_cfg, .ready_mask
    );

    memtest_rd_requester u_rd_requester (
        .clk, .state_reset, .start, .state_run, .rd_cfg,
        .arvalid, .ar, .arready, .rd_state
    );

    memtest_rd_monitor u_rd_monitor (
        .clk, .state_reset, .start, .ready_mask, .arvalid, .arready,
        .rvalid, .r, .rready, .checksum, .events
    );

    // ============================
    // One counter per event strobe
    // ============================
    for (genvar i = 0; i < NUM_EVENTS; i++)
    begin : g_event_counter
        memtest_event_counter #(.COUNTER_WIDTH(COUNTER_WIDTH)) u_counter (
            .clk, .state_reset, .start,
            .incr  (events[i]),
            .value (counts[i])
        );
    end

    memtest_status_readback #(
        .COUNTER_WIDTH (COUNTER_WIDTH),
        .ENGINE_NUMBER (ENGINE_NUMBER)
    ) u_status_readback (
        .clk, .state_reset, .state_run, .rd_state, .counts, .checksum,
        .csr_rd_idx, .csr_rd_data, .active
    );

endmodule

`default_nettype wire

/* testbench/memtest_engine_assert.sv */
// ==============================
// AR channel assertions for the read test engine
// ==============================
`timescale 1ns/1ns
`default_nettype none

module memtest_engine_assert
(
    input wire logic                   clk,
    input wire logic                   state_reset,
    input wire logic                   start,
    input wire logic                   arvalid,
    input wire logic                   arready,
    input wire memtest_pkg::ar_req_t   ar,
    input wire memtest_pkg::rd_state_e rd_state
);

    import memtest_pkg::*;

    // Stalled request keeps its payload until taken
    ar_stable: assert property (@(posedge clk) disable iff (state_reset || start)
        (arvalid && !arready) |=> (arvalid && $stable(ar)))
        else $error("AR request changed or dropped before arready");

    // Nothing requested coming out of reset
    ar_reset_low: assert property (@(posedge clk) state_reset |=> !arvalid)
        else $error("arvalid high right after reset");

    // Done is entered only on an accepted request and leaves the channel quiet
    ar_done_low: assert property (@(posedge clk) disable iff (state_reset)
        ((rd_state == RD_DONE) && ($past(rd_state) != RD_DONE) && !$past(start))
        |-> ($past(arvalid && arready) && !arvalid))
        else $error("requester finished without an accepted request or kept arvalid high");

endmodule

bind memtest_engine_top memtest_engine_assert u_engine_assert (
    .clk, .state_reset, .start, .arvalid, .arready, .ar, .rd_state
);

`default_nettype wire

/* testbench/tb_memtest_engine.sv */
// ==============================
// Testbench for the memory read test engine
// Memory responder model, table driven runs and CSR checks
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_memtest_engine;

    import memtest_pkg::*;

    localparam int         CLK_PERIOD    = 40;
    localparam int         COUNTER_WIDTH = 48;
    localparam logic [4:0] ENGINE_NUM    = 5'd19;
    localparam int         NUM_ROWS      = 6;

    // One run where exp_bursts is the stop point for a zero burst count
    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0]  base;
        logic [NUM_BURSTS_WIDTH-1:0] bursts;
        logic [BURST_LEN_WIDTH-1:0]  len;
        logic [OFFSET_WIDTH-1:0]     offset;
        logic [OFFSET_WIDTH-1:0]     mask;
        logic [31:0]                 ready;
        logic [15:0]                 exp_bursts;
    } row_t;

    logic                      clk = 1'b0;
    logic                      state_reset;
    logic                      csr_wr;
    csr_idx_e                  csr_wr_idx;
    logic [CSR_DATA_WIDTH-1:0] csr_wr_data;
    csr_idx_e                  csr_rd_idx;
    logic [CSR_DATA_WIDTH-1:0] csr_rd_data;
    logic                      start;
    logic                      state_run;
    logic                      active;
    logic                      arvalid;
    ar_req_t                   ar;
    logic                      arready = 1'b0;
    logic                      rvalid = 1'b0;
    r_beat_t                   r = '0;
    logic                      rready;

    // Test table and the row in flight
    row_t        rows [NUM_ROWS];
    string       row_names [NUM_ROWS];
    bit          table_loaded = 1'b0;
    row_t        cur;
    string       cur_name;

    // Memory model state
    integer      seed = 10966;
    ar_req_t     r_q [$];
    logic [7:0]  beat_idx = '0;
    bit          r_enable = 1'b0;
    int          ar_count = 0;
    logic [31:0] sum = '0;
    bit          ar_fire = 1'b0;
    bit          r_fire = 1'b0;
    ar_req_t     ar_seen;
    r_beat_t     r_seen;

    memtest_engine_top #(
        .COUNTER_WIDTH (COUNTER_WIDTH),
        .ENGINE_NUMBER (ENGINE_NUM)
    ) dut (
        .clk, .state_reset, .csr_wr, .csr_wr_idx, .csr_wr_data,
        .csr_rd_idx, .csr_rd_data, .start, .state_run, .active,
        .arvalid, .ar, .arready, .rvalid, .r, .rready
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", label, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic write_csr(input csr_idx_e idx, input logic [63:0] data);
        @(posedge clk);
        csr_wr      <= 1'b1;
        csr_wr_idx  <= idx;
        csr_wr_data <= data;
        @(posedge clk);
        csr_wr      <= 1'b0;
    endtask

    // Read mux is combinational so the value is taken mid cycle
    task automatic read_csr(input csr_idx_e idx, output logic [63:0] value);
        @(posedge clk);
        csr_rd_idx <= idx;
        @(negedge clk);
        value = csr_rd_data;
    endtask

    // Idle means no AR, no beats owed and active low for a few cycles in a row
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4)
        begin
            @(negedge clk);
            if (r_q.size() == 0 && !arvalid && !active)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    task automatic load_table();
        rows[0] = '{29'h0001000, 16'd4, 8'd4, 16'h0000, 16'hffff, 32'hffff_ffff, 16'd4};
        row_names[0] = "basic";
        // Offset steps past the mask and wraps to low lines
        rows[1] = '{29'h0020000, 16'd8, 8'd16, 16'h0030, 16'h003f, 32'ha5a5_5a5a, 16'd8};
        row_names[1] = "mask_wrap";
        rows[2] = '{29'h00abc00, 16'd10, 8'd1, 16'h0005, 16'h00ff, 32'h0f0f_3c3c, 16'd10};
        row_names[2] = "single_line";
        // Offset wraps at 16 bits
        rows[3] = '{29'h1000000, 16'd3, 8'd40, 16'hfff0, 16'hffff, 32'h1248_8421, 16'd3};
        row_names[3] = "long_burst";
        rows[4] = '{29'h0000000, 16'd5, 8'd2, 16'h0000, 16'hffff, 32'h8000_0001, 16'd0};
        row_names[4] = "no_base";
        rows[5] = '{29'h0040000, 16'd0, 8'd3, 16'h0000, 16'h00ff, 32'hffff_0000, 16'd40};
        row_names[5] = "unlimited";
    endtask

    // ==============================
    // Memory responder
    // ==============================
    // Handshakes are judged mid cycle and acted on at the next edge
    always @(negedge clk)
    begin
        ar_fire = arvalid && arready && !state_reset;
        ar_seen = ar;
        r_fire  = rvalid && rready && !state_reset;
        r_seen  = r;
    end

    always @(posedge clk)
    begin : memory_model
        logic [OFFSET_WIDTH-1:0]    off;
        logic [LINE_ADDR_WIDTH-1:0] exp_line;
        r_beat_t                    nxt;
        if (r_fire)
        begin
            sum = sum + r_seen.data[31:0];
            if (beat_idx == r_q[0].len)
            begin
                void'(r_q.pop_front());
                beat_idx = '0;
            end
            else
                beat_idx++;
        end
        if (ar_fire)
        begin
            // Line is base ORed with the masked running offset
            off      = cur.offset + OFFSET_WIDTH'(ar_count * int'(cur.len));
            exp_line = cur.base | LINE_ADDR_WIDTH'(off & cur.mask);
            check_value({cur_name, " ar addr"}, 64'({exp_line, 3'b000}), 64'(ar_seen.addr));
            check_value({cur_name, " ar len"}, 64'(cur.len - 8'd1), 64'(ar_seen.len));
            check_value({cur_name, " ar id"}, 64'(ar_count[3:0]), 64'(ar_seen.id));
            r_q.push_back(ar_seen);
            ar_count++;
        end
        arready <= ($random(seed) & 3) != 0;
        if (r_enable && r_q.size() != 0)
        begin
            // Each beat carries its own line address
            nxt.data = DATA_WIDTH'(r_q[0].addr[31:BYTE_IDX_WIDTH] + LINE_ADDR_WIDTH'(beat_idx));
            nxt.last = (beat_idx == r_q[0].len);
            r        <= nxt;
            rvalid   <= ($random(seed) & 3) != 0;
        end
        else
            rvalid <= 1'b0;
    end

    // Limit scales with the beats each row can return
    initial
    begin : watchdog
        longint limit;
        int     n;
        wait (table_loaded);
        limit = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            n = (rows[i].bursts == '0) ? int'(rows[i].exp_bursts) + 1 : int'(rows[i].bursts);
            limit += longint'(n) * rows[i].len * 64 + 500;
        end
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    // ==============================
    // Table driven runs
    // ==============================
    initial
    begin : main
        logic [63:0] rd_val;
        int          exp_req;
        state_reset = 1'b1;
        csr_wr      = 1'b0;
        csr_wr_idx  = CSR_RD_BASE;
        csr_wr_data = '0;
        csr_rd_idx  = CSR_CONFIG;
        start       = 1'b0;
        state_run   = 1'b0;
        load_table();
        table_loaded = 1'b1;
        repeat (3) @(posedge clk);
        state_reset <= 1'b0;

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            @(negedge clk);
            cur        = rows[i];
            cur_name   = row_names[i];
            ar_count   = 0;
            sum        = '0;
            r_enable   = 1'b0;
            write_csr(CSR_RD_BASE, 64'(cur.base));
            write_csr(CSR_RD_CTRL, {16'd0, cur.bursts, cur.offset, 8'd0, cur.len});
            write_csr(CSR_ADDR_MASK, 64'(cur.mask));
            write_csr(CSR_READY_MASK, 64'(cur.ready));
            @(posedge clk);
            start     <= 1'b1;
            state_run <= 1'b1;
            @(posedge clk);
            start     <= 1'b0;

            // R stays idle so only the rotating mask drives rready
            for (int k = 0; k < 32; k++)
            begin
                @(negedge clk);
                check_value($sformatf("%s rready cycle %0d", cur_name, k),
                            64'(cur.ready[k]), 64'(rready));
            end
            r_enable = 1'b1;

            exp_req = int'(cur.exp_bursts);
            if (cur.bursts == '0 && cur.base != '0)
            begin
                while (ar_count < int'(cur.exp_bursts))
                    @(negedge clk);
                // A request already up still completes after run drops
                exp_req = ar_count + int'(arvalid);
                @(posedge clk);
                state_run <= 1'b0;
            end
            wait_idle();

            check_value({cur_name, " model bursts"}, 64'(exp_req), 64'(ar_count));
            read_csr(CSR_BURSTS_REQ, rd_val);
            check_value({cur_name, " bursts requested"}, 64'(exp_req), rd_val);
            read_csr(CSR_BURSTS_RESP, rd_val);
            check_value({cur_name, " bursts completed"}, 64'(exp_req), rd_val);
            read_csr(CSR_LINES_RESP, rd_val);
            check_value({cur_name, " lines"}, 64'(exp_req * int'(cur.len)), rd_val);
            read_csr(CSR_CHECKSUM, rd_val);
            check_value({cur_name, " checksum"}, 64'(sum), rd_val);

            @(posedge clk);
            state_run <= 1'b0;
            read_csr(CSR_CONFIG, rd_val);
            check_value({cur_name, " config"}, (64'(ENGINE_NUM) << 42) | 64'd255, rd_val);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/memtest_pkg.sv
design/memtest_csr_regs.sv
design/memtest_rd_requester.sv
design/memtest_rd_monitor.sv
design/memtest_event_counter.sv
design/memtest_status_readback.sv
design/memtest_engine_top.sv
testbench/memtest_engine_assert.sv
testbench/tb_memtest_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for the result
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing --assert -Wno-fatal --top-module tb_memtest_engine \
    -f files.f -o memtest_sim \
    && ./obj_dir/memtest_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "Result: fail"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Result: no pass line in log"; exit 1; }
echo "Result: pass"
